// File: ctrl_defines.svh
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// instruction fields

// width of OPCODE and Funct
`define FIELD_WIDTH 6

// step counter

// wide enough for the longest phase
`define STEP_WIDTH 3

// fetch covers the memory read and the IR load
`define FETCH_STEPS 3

// register read and branch target add
`define DECODE_STEPS 2

`endif

// File: isaPkg.sv
`include "ctrl_defines.svh"

package isaPkg;

    // primary opcode, instruction bits 31:26
    typedef enum logic [`FIELD_WIDTH-1:0] {
        OP_RFORMAT = 6'b000000,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_ADDI    = 6'b001000,
        OP_SLTI    = 6'b001010,
        OP_LUI     = 6'b001111
    } opcode_e;

    // funct field of R-format words
    typedef enum logic [`FIELD_WIDTH-1:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_ADD  = 6'b100000,
        FN_SUB  = 6'b100010,
        FN_AND  = 6'b100100,
        FN_SLT  = 6'b101010
    } funct_e;

    // one entry per supported instruction
    typedef enum logic [4:0] {
        KIND_ADD,
        KIND_SUB,
        KIND_AND,
        KIND_SLT,
        KIND_SLL,
        KIND_SRL,
        KIND_SRA,
        KIND_SLLV,
        KIND_SRAV,
        KIND_JR,
        KIND_J,
        KIND_JAL,
        KIND_ADDI,
        KIND_LUI,
        KIND_SLTI,
        KIND_UNKNOWN
    } instrKind_e;

endpackage

// File: ctrlPkg.sv
package ctrlPkg;

    // main sequencer states
    typedef enum logic [1:0] {
        ST_RESET   = 2'b00,
        ST_FETCH   = 2'b01,
        ST_DECODE  = 2'b10,
        ST_EXECUTE = 2'b11
    } state_e;

    // alu function codes
    typedef enum logic [2:0] {
        ALU_PASS = 3'b000,
        ALU_ADD  = 3'b001,
        ALU_SUB  = 3'b010,
        ALU_AND  = 3'b011,
        ALU_LESS = 3'b111
    } aluOp_e;

    // shift register commands
    typedef enum logic [2:0] {
        SH_NONE          = 3'b000,
        SH_LOAD          = 3'b001,
        SH_LEFT          = 3'b010,
        SH_RIGHT_LOGICAL = 3'b011,
        SH_RIGHT_ARITH   = 3'b100
    } shiftOp_e;

    typedef enum logic [1:0] {
        SRCA_PC    = 2'b00,
        SRCA_REG_A = 2'b01
    } aluSrcA_e;

    typedef enum logic [1:0] {
        SRCB_REG_B       = 2'b00,
        SRCB_FOUR        = 2'b01,
        SRCB_IMM         = 2'b10,
        SRCB_SHIFTED_IMM = 2'b11
    } aluSrcB_e;

    typedef enum logic [2:0] {
        PC_ALU_RESULT = 3'b000,
        PC_JUMP       = 3'b010
    } pcSource_e;

    // register file write address select
    typedef enum logic [2:0] {
        DEST_RT   = 3'b000,
        DEST_RD   = 3'b001,
        DEST_SP   = 3'b010,
        DEST_LINK = 3'b101
    } regDest_e;

    // register file write data select
    typedef enum logic [3:0] {
        DATA_ALU_OUT   = 4'b0000,
        DATA_UPPER_IMM = 4'b0101,
        DATA_SHIFTER   = 4'b0111,
        DATA_SP_INIT   = 4'b1000
    } regData_e;

    // datapath mux selects
    typedef struct packed {
        aluSrcA_e  aluSrcA;
        aluSrcB_e  aluSrcB;
        pcSource_e pcSource;
        regDest_e  regDest;
        regData_e  regData;
        logic      shiftSrc;
        logic      shiftAmt;
    } muxSel_t;

    // enables and unit commands
    typedef struct packed {
        logic     pcWrite;
        logic     irWrite;
        logic     regWrite;
        logic     aLoad;
        logic     bLoad;
        aluOp_e   aluOp;
        logic     aluOutLoad;
        logic     signExtend;
        shiftOp_e shiftOp;
    } unitCtrl_t;

    // 29 bits, selects in the upper part
    typedef struct packed {
        muxSel_t   sel;
        unitCtrl_t unit;
    } ctrlWord_t;

endpackage

// File: instrDecoder.sv
module instrDecoder (
    input  isaPkg::opcode_e    opcode,
    input  isaPkg::funct_e     funct,
    output isaPkg::instrKind_e kind
);

    import isaPkg::*;

    instrKind_e rKind;
    instrKind_e iKind;

    // R-format words are told apart by funct alone
    always_comb begin
        case (funct)
            FN_ADD:  rKind = KIND_ADD;
            FN_SUB:  rKind = KIND_SUB;
            FN_AND:  rKind = KIND_AND;
            FN_SLT:  rKind = KIND_SLT;
            FN_SLL:  rKind = KIND_SLL;
            FN_SRL:  rKind = KIND_SRL;
            FN_SRA:  rKind = KIND_SRA;
            FN_SLLV: rKind = KIND_SLLV;
            FN_SRAV: rKind = KIND_SRAV;
            FN_JR:   rKind = KIND_JR;
            default: rKind = KIND_UNKNOWN;
        endcase
    end

    // I and J formats
    always_comb begin
        case (opcode)
            OP_ADDI: iKind = KIND_ADDI;
            OP_SLTI: iKind = KIND_SLTI;
            OP_LUI:  iKind = KIND_LUI;
            OP_J:    iKind = KIND_J;
            OP_JAL:  iKind = KIND_JAL;
            default: iKind = KIND_UNKNOWN;
        endcase
    end

    // funct only matters for the R-format opcode
    assign kind = (opcode == OP_RFORMAT) ? rKind : iKind;

endmodule

// File: stepSequencer.sv
`include "ctrl_defines.svh"

module stepSequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  isaPkg::instrKind_e      kind,
    output ctrlPkg::state_e         state,
    output logic [`STEP_WIDTH-1:0]  step,
    output logic                    resetOut
);

    import isaPkg::*;
    import ctrlPkg::*;

    logic lastStep;

    // execute cycles needed by each instruction
    function automatic logic [`STEP_WIDTH-1:0] execLength(instrKind_e k);
        case (k)
            KIND_SLL, KIND_SRL, KIND_SRA, KIND_SLLV, KIND_SRAV:
                return `STEP_WIDTH'(4);
            KIND_JR, KIND_J, KIND_LUI, KIND_UNKNOWN:
                return `STEP_WIDTH'(1);
            default:
                return `STEP_WIDTH'(2);
        endcase
    endfunction

    function automatic logic [`STEP_WIDTH-1:0] phaseLength(state_e s, instrKind_e k);
        case (s)
            ST_FETCH:   return `STEP_WIDTH'(`FETCH_STEPS);
            ST_DECODE:  return `STEP_WIDTH'(`DECODE_STEPS);
            ST_EXECUTE: return execLength(k);
            default:    return `STEP_WIDTH'(1);
        endcase
    endfunction

    assign lastStep = (step == phaseLength(state, kind) - 1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RESET;
            step  <= '0;
        end else if (lastStep) begin
            step <= '0;
            case (state)
                ST_RESET:  state <= ST_FETCH;
                ST_FETCH:  state <= ST_DECODE;
                ST_DECODE: state <= ST_EXECUTE;
                default:   state <= ST_FETCH;
            endcase
        end else begin
            step <= step + 1'b1;
        end
    end

    // tells the datapath the stack pointer load is in progress
    assign resetOut = (state == ST_RESET);

    // kind is held by the datapath for the whole execute phase
    stepInRange: assert property (
        @(posedge clk) disable iff (reset)
        step < phaseLength(state, kind)
    ) else $error("step %0d past end of phase %s", step, state.name());

    // decode must run its full length before execute starts
    executeEntry: assert property (
        @(posedge clk) disable iff (reset)
        (state == ST_EXECUTE && $past(state) != ST_EXECUTE) |->
            ($past(state) == ST_DECODE &&
             $past(step) == `STEP_WIDTH'(`DECODE_STEPS - 1))
    ) else $error("execute entered without a full decode phase");

endmodule

// File: controlEncoder.sv
`include "ctrl_defines.svh"

module controlEncoder (
    input  ctrlPkg::state_e         state,
    input  logic [`STEP_WIDTH-1:0]  step,
    input  isaPkg::instrKind_e      kind,
    output ctrlPkg::ctrlWord_t      ctrl
);

    import isaPkg::*;
    import ctrlPkg::*;

    logic immForm;

    function automatic aluOp_e aluOpFor(instrKind_e k);
        case (k)
            KIND_SUB:            return ALU_SUB;
            KIND_AND:            return ALU_AND;
            KIND_SLT, KIND_SLTI: return ALU_LESS;
            default:             return ALU_ADD;
        endcase
    endfunction

    function automatic shiftOp_e shiftDirFor(instrKind_e k);
        case (k)
            KIND_SRL:           return SH_RIGHT_LOGICAL;
            KIND_SRA, KIND_SRAV: return SH_RIGHT_ARITH;
            default:            return SH_LEFT;
        endcase
    endfunction

    // operand comes from the immediate or shamt field
    assign immForm = (kind == KIND_ADDI) || (kind == KIND_SLTI) ||
                     (kind == KIND_SLL) || (kind == KIND_SRL) || (kind == KIND_SRA);

    always_comb begin
        ctrl = '0;
        case (state)
            ST_RESET: begin
                // load the stack pointer with its initial value
                ctrl.unit.regWrite = 1'b1;
                ctrl.sel.regDest   = DEST_SP;
                ctrl.sel.regData   = DATA_SP_INIT;
            end
            ST_FETCH: begin
                // pc + 4 on every fetch step
                ctrl.unit.aluOp   = ALU_ADD;
                ctrl.sel.aluSrcB  = SRCB_FOUR;
                if (step == `STEP_WIDTH'(`FETCH_STEPS - 1)) begin
                    ctrl.unit.pcWrite = 1'b1;
                    ctrl.unit.irWrite = 1'b1;
                end
            end
            ST_DECODE: begin
                // read rs/rt and precompute the branch target
                ctrl.unit.aLoad      = 1'b1;
                ctrl.unit.bLoad      = 1'b1;
                ctrl.unit.aluOutLoad = 1'b1;
                ctrl.unit.signExtend = 1'b1;
                ctrl.unit.aluOp      = ALU_ADD;
                ctrl.sel.aluSrcA     = SRCA_PC;
                ctrl.sel.aluSrcB     = SRCB_SHIFTED_IMM;
            end
            default: begin
                case (kind)
                    KIND_ADD, KIND_SUB, KIND_AND, KIND_SLT, KIND_ADDI, KIND_SLTI: begin
                        ctrl.sel.aluSrcA = SRCA_REG_A;
                        ctrl.sel.aluSrcB = immForm ? SRCB_IMM : SRCB_REG_B;
                        if (step == '0) begin
                            ctrl.unit.aluOp      = aluOpFor(kind);
                            ctrl.unit.aluOutLoad = 1'b1;
                            ctrl.unit.signExtend = (kind == KIND_SLTI);
                        end else begin
                            ctrl.unit.regWrite = 1'b1;
                            ctrl.sel.regDest   = immForm ? DEST_RT : DEST_RD;
                            ctrl.sel.regData   = DATA_ALU_OUT;
                        end
                    end
                    KIND_SLL, KIND_SRL, KIND_SRA, KIND_SLLV, KIND_SRAV: begin
                        ctrl.sel.shiftSrc = immForm;
                        ctrl.sel.shiftAmt = immForm;
                        if (step < `STEP_WIDTH'(2)) begin
                            ctrl.unit.shiftOp = SH_LOAD;
                        end else if (step == `STEP_WIDTH'(2)) begin
                            ctrl.unit.shiftOp = shiftDirFor(kind);
                        end else begin
                            ctrl.unit.regWrite = 1'b1;
                            ctrl.sel.regDest   = DEST_RD;
                            ctrl.sel.regData   = DATA_SHIFTER;
                        end
                    end
                    KIND_JR: begin
                        ctrl.unit.pcWrite = 1'b1;
                        ctrl.unit.aluOp   = ALU_PASS;
                        ctrl.sel.aluSrcA  = SRCA_REG_A;
                        ctrl.sel.pcSource = PC_ALU_RESULT;
                    end
                    KIND_J: begin
                        ctrl.unit.pcWrite = 1'b1;
                        ctrl.sel.pcSource = PC_JUMP;
                    end
                    KIND_JAL: begin
                        if (step == '0) begin
                            // return address is the already incremented pc
                            ctrl.unit.aluOp      = ALU_PASS;
                            ctrl.unit.aluOutLoad = 1'b1;
                            ctrl.sel.aluSrcA     = SRCA_PC;
                        end else begin
                            ctrl.unit.pcWrite  = 1'b1;
                            ctrl.sel.pcSource  = PC_JUMP;
                            ctrl.unit.regWrite = 1'b1;
                            ctrl.sel.regDest   = DEST_LINK;
                            ctrl.sel.regData   = DATA_ALU_OUT;
                        end
                    end
                    KIND_LUI: begin
                        ctrl.unit.regWrite = 1'b1;
                        ctrl.sel.regDest   = DEST_RT;
                        ctrl.sel.regData   = DATA_UPPER_IMM;
                    end
                    // unknown code idles for one cycle
                    default: ;
                endcase
            end
        endcase
    end

    // only jal updates pc and the register file together
    always_comb begin
        pcRegWrite: assert final (!(ctrl.unit.regWrite && ctrl.unit.pcWrite) ||
                                  (state == ST_EXECUTE && kind == KIND_JAL &&
                                   step == `STEP_WIDTH'(1)))
            else $error("pcWrite with regWrite in %s step %0d", state.name(), step);
    end

endmodule

// File: controlUnit.sv
`include "ctrl_defines.svh"

module controlUnit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`FIELD_WIDTH-1:0] opcode,
    input  logic [`FIELD_WIDTH-1:0] funct,
    output ctrlPkg::ctrlWord_t      ctrl,
    output logic                    resetOut
);

    import isaPkg::*;
    import ctrlPkg::*;

    opcode_e                opcodeCode;
    funct_e                 functCode;
    instrKind_e             kind;
    state_e                 state;
    logic [`STEP_WIDTH-1:0] step;

    // unlisted codes pass through the cast and decode as unknown
    assign opcodeCode = opcode_e'(opcode);
    assign functCode  = funct_e'(funct);

    instrDecoder decoder (
        .opcode (opcodeCode),
        .funct  (functCode),
        .kind   (kind)
    );

    stepSequencer sequencer (
        .clk      (clk),
        .reset    (reset),
        .kind     (kind),
        .state    (state),
        .step     (step),
        .resetOut (resetOut)
    );

    controlEncoder encoder (
        .state (state),
        .step  (step),
        .kind  (kind),
        .ctrl  (ctrl)
    );

endmodule

// File: controlChecker.sv
module controlChecker (
    input  logic               clk,
    input  logic               checkEn,
    input  ctrlPkg::ctrlWord_t ctrl,
    input  logic               resetOut,
    input  ctrlPkg::ctrlWord_t expCtrl,
    input  logic               expResetOut,
    output int                 errorCount,
    output int                 checkCount
);

    timeunit 1ns;
    timeprecision 1ps;

    // one clock is 20 ns, so this lands just ahead of the next edge
    localparam int SAMPLE_OFFSET = 19;

    int errors = 0;
    int checks = 0;

    assign errorCount = errors;
    assign checkCount = checks;

    always @(posedge clk) begin
        #(SAMPLE_OFFSET);
        if (checkEn) begin
            checks = checks + 1;
            if (ctrl !== expCtrl) begin
                errors = errors + 1;
                $display("Error at %0d ns: ctrl expected %h, got %h",
                         $time, expCtrl, ctrl);
            end
            if (resetOut !== expResetOut) begin
                errors = errors + 1;
                $display("Error at %0d ns: resetOut expected %b, got %b",
                         $time, expResetOut, resetOut);
            end
        end
    end

endmodule

// File: tbControlUnit.sv
`include "ctrl_defines.svh"

module tbControlUnit;

    timeunit 1ns;
    timeprecision 1ps;

    import ctrlPkg::*;

    localparam int PERIOD       = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_WORDS    = 1024;

    logic                    clk = 1'b0;
    logic                    reset;
    logic [`FIELD_WIDTH-1:0] opcode;
    logic [`FIELD_WIDTH-1:0] funct;
    ctrlWord_t               ctrl;
    logic                    resetOut;
    logic                    checkEn;
    ctrlWord_t               expCtrl;
    logic                    expResetOut;
    int                      errorCount;
    int                      checkCount;
    int                      totalCycles = 0;
    logic [31:0]             vecMem [0:MAX_WORDS-1];

    always #(PERIOD / 2) clk = ~clk;

    controlUnit DUT (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .ctrl     (ctrl),
        .resetOut (resetOut)
    );

    controlChecker outChecker (
        .clk         (clk),
        .checkEn     (checkEn),
        .ctrl        (ctrl),
        .resetOut    (resetOut),
        .expCtrl     (expCtrl),
        .expResetOut (expResetOut),
        .errorCount  (errorCount),
        .checkCount  (checkCount)
    );

    // group header is reset, opcode, funct, resetOut, cycles; zero cycles ends the list
    function automatic int countCycles();
        int idx = 0;
        int sum = 0;
        while (idx + 4 < MAX_WORDS && vecMem[idx + 4] != 0) begin
            sum = sum + int'(vecMem[idx + 4]);
            idx = idx + 5 + int'(vecMem[idx + 4]);
        end
        return sum;
    endfunction

    initial begin
        int idx;
        int count;
        int setupErrors;
        reset       = 1'b1;
        opcode      = '0;
        funct       = '0;
        checkEn     = 1'b0;
        expCtrl     = '0;
        expResetOut = 1'b0;
        setupErrors = 0;
        $readmemh("control_vectors.txt", vecMem);
        totalCycles = countCycles();
        if (totalCycles == 0) begin
            $display("no vector groups found in control_vectors.txt");
            setupErrors = 1;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        idx = 0;
        while (idx + 4 < MAX_WORDS && vecMem[idx + 4] != 0) begin
            count = int'(vecMem[idx + 4]);
            for (int c = 0; c < count; c++) begin
                #(DRIVE_DELAY);
                reset       = vecMem[idx][0];
                opcode      = vecMem[idx + 1][`FIELD_WIDTH-1:0];
                funct       = vecMem[idx + 2][`FIELD_WIDTH-1:0];
                expResetOut = vecMem[idx + 3][0];
                expCtrl     = vecMem[idx + 5 + c][$bits(ctrlWord_t)-1:0];
                checkEn     = 1'b1;
                @(posedge clk);
            end
            idx = idx + 5 + count;
        end
        #(DRIVE_DELAY);
        checkEn = 1'b0;
        $display("%0d checks, %0d errors", checkCount, errorCount + setupErrors);
        if (errorCount == 0 && setupErrors == 0 && checkCount > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // vector cycles plus reset plus some slack
    initial begin
        wait (totalCycles > 0);
        #((totalCycles + RESET_CYCLES + 10) * PERIOD);
        $display("timeout: vectors did not finish within %0d cycles",
                 totalCycles + RESET_CYCLES + 10);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: control_vectors.txt
// reset opcode funct resetOut cycles, then one expected ctrl word per cycle
// a group with zero cycles ends the list
// reset held, then released
1 00 00 1 2 00140400 00140400
0 00 00 1 1 00140400
// ADD SUB AND SLT
0 00 20 0 7 02000020 02000020 02001820 06000338 06000338 08000030 08080400
0 00 22 0 7 02000020 02000020 02001820 06000338 06000338 08000050 08080400
0 00 24 0 7 02000020 02000020 02001820 06000338 06000338 08000070 08080400
0 00 2a 0 7 02000020 02000020 02001820 06000338 06000338 080000f0 08080400
// SLL SRL SRA SLLV SRAV
0 00 00 0 9 02000020 02000020 02001820 06000338 06000338 00006001 00006001 00006002 000be400
0 00 02 0 9 02000020 02000020 02001820 06000338 06000338 00006001 00006001 00006003 000be400
0 00 03 0 9 02000020 02000020 02001820 06000338 06000338 00006001 00006001 00006004 000be400
0 00 04 0 9 02000020 02000020 02001820 06000338 06000338 00000001 00000001 00000002 000b8400
0 00 07 0 9 02000020 02000020 02001820 06000338 06000338 00000001 00000001 00000004 000b8400
// JR J JAL
0 00 08 0 6 02000020 02000020 02001820 06000338 06000338 08001000
0 02 00 0 6 02000020 02000020 02001820 06000338 06000338 00801000
0 03 00 0 7 02000020 02000020 02001820 06000338 06000338 00000010 00a81400
// ADDI SLTI LUI
0 08 00 0 7 02000020 02000020 02001820 06000338 06000338 0c000030 0c000400
0 0a 00 0 7 02000020 02000020 02001820 06000338 06000338 0c0000f8 0c000400
0 0f 00 0 6 02000020 02000020 02001820 06000338 06000338 00028400
// unknown opcode, then unknown funct
0 3f 00 0 6 02000020 02000020 02001820 06000338 06000338 00000000
0 00 3f 0 6 02000020 02000020 02001820 06000338 06000338 00000000
// reset during fetch, release, then one more ADD
1 00 20 0 1 02000020
1 00 20 1 1 00140400
0 00 00 1 1 00140400
0 00 20 0 7 02000020 02000020 02001820 06000338 06000338 08000030 08080400
0 00 00 0 0

// File: flist.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
instrDecoder.sv
stepSequencer.sv
controlEncoder.sv
controlUnit.sv
controlChecker.sv
tbControlUnit.sv

// File: Makefile
SHELL     := /bin/bash

VERILATOR ?= verilator
TOP       ?= tbControlUnit
LOG       ?= sim.log
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES   := $(filter %.sv %.v,$(shell cat $(FLIST)))
HEADERS   := ctrl_defines.svh
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FLIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN) control_vectors.txt
	set -o pipefail; ./$(BIN) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
